/* Bender.yml */
package:
  name: nzi_read_req_gen

sources:
  - source/smem_pkg.sv
  - source/proc_pkg.sv
  - source/nzi_cfg_fsm.sv
  - source/nest_counter.sv
  - source/nzl_pointer.sv
  - source/rd_req_stage.sv
  - source/nzi_read_req_gen.sv
  - target: simulation
    files:
      - sim/nzi_read_req_gen_assert.sv
      - sim/nzi_read_req_gen_tb.sv

/* sim/nzi_read_req_gen_assert.sv */
`timescale 1ns/100ps

module nzi_read_req_gen_assert import smem_pkg::*; (
    input logic              clk,
    input logic              rstn,
    input logic              cfg_ready,
    input logic              empty_nzn,
    input logic              pop_nzn,
    input logic [ADDR_W-1:0] rd_addr,
    input logic [WSEL_W-1:0] rd_wsel,
    input logic              rd_avalid,
    input logic              rd_aready
);

    // Stalled request holds its payload
    a_req_stable: assert property (@(posedge clk) disable iff (!rstn)
        rd_avalid && !rd_aready |=> $stable(rd_addr) && $stable(rd_wsel))
        else $error("rd_addr or rd_wsel changed while the request was stalled");

    a_valid_held: assert property (@(posedge clk) disable iff (!rstn)
        rd_avalid && !rd_aready |=> rd_avalid)
        else $error("rd_avalid fell without a transfer");

    // One pop pulse, taken from a non-empty queue
    a_pop_nonempty: assert property (@(posedge clk) disable iff (!rstn)
        pop_nzn |-> !empty_nzn ##1 !pop_nzn)
        else $error("pop_nzn raised on an empty queue or held for more than one cycle");

    // Host is released only with the channel drained
    a_ready_idle: assert property (@(posedge clk) disable iff (!rstn)
        !(cfg_ready && rd_avalid))
        else $error("cfg_ready and rd_avalid high together");

endmodule

bind nzi_read_req_gen nzi_read_req_gen_assert u_assert (.*);

/* sim/nzi_read_req_gen_tb.sv */
`timescale 1ns/100ps

module nzi_read_req_gen_tb import smem_pkg::*, proc_pkg::*; ();

    localparam int TIMEOUT = 2000;

    logic                clk;
    logic                rstn;
    logic                cfg_valid;
    logic [PROC_W-1:0]   cfg_proc;
    logic [CNT_W-1:0]    cfg_cnt0;
    logic [CNT_W-1:0]    cfg_cnt1;
    logic [CNT_W-1:0]    cfg_cnt2;
    logic [ADDR_W-1:0]   smem_addr0;
    logic [NZL_HA_W-1:0] nzl_head_addr;
    logic [PEID_W-1:0]   nzl_head_peid;
    logic                cfg_ready;
    logic [CNT_W-1:0]    din_nzn;
    logic                empty_nzn;
    logic                pop_nzn;
    logic [ADDR_W-1:0]   rd_addr;
    logic [WSEL_W-1:0]   rd_wsel;
    logic                rd_avalid;
    logic                rd_aready;

    integer seed = 57436;
    logic   pop_allowed;

    // Current case from the trace
    logic [PROC_W-1:0]   c_proc;
    logic [CNT_W-1:0]    c_lim0;
    logic [CNT_W-1:0]    c_lim1;
    logic [CNT_W-1:0]    c_lim2;
    logic [ADDR_W-1:0]   c_base;
    logic [NZL_HA_W-1:0] c_haddr;
    logic [PEID_W-1:0]   c_hpeid;
    logic [CNT_W-1:0]    c_nzn;

    // Expected requests as {rd_addr, rd_wsel}
    logic [ADDR_W+WSEL_W-1:0] exp_q[$];

    nzi_read_req_gen dut (.*);

    always #2 clk = ~clk;

    // Random back-pressure on the read channel
    always @(posedge clk) begin
        rd_aready <= rstn && (($random(seed) & 3) != 0);
    end

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "testbench stopped at the first error");
    endtask

    task automatic check_addr(input string name, input logic [ADDR_W-1:0] got,
                              input logic [ADDR_W-1:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_wsel(input string name, input logic [WSEL_W-1:0] got,
                              input logic [WSEL_W-1:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    // Transfers are sampled at the falling edge before the edge that takes them
    always @(negedge clk) begin
        if (rstn && pop_nzn) begin
            check_flag("pop_nzn", pop_nzn, pop_allowed);
            pop_allowed = 1'b0;
        end
        if (rstn && rd_avalid && rd_aready) begin
            if (exp_q.size() == 0) begin
                stop_run("A read request was issued beyond the expected stream");
            end
            check_addr("rd_addr", rd_addr, exp_q[0][ADDR_W+WSEL_W-1:WSEL_W]);
            check_wsel("rd_wsel", rd_wsel, exp_q[0][WSEL_W-1:0]);
            void'(exp_q.pop_front());
        end
    end

    // ------------------------------------------------------------------------
    // Waits and case sequence
    // ------------------------------------------------------------------------

    task automatic wait_cfg_ready(input string what);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) begin
                stop_run({"Timed out waiting for cfg_ready ", what});
            end
        end while (!cfg_ready);
    endtask

    task automatic wait_pop();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) begin
                stop_run("Timed out waiting for the nonzero count pop");
            end
        end while (!pop_nzn);
    endtask

    task automatic run_case();
        int   hold;
        int   n_req;
        logic sparse;
        sparse = (c_proc == PROC_MXV_SP) || (c_proc == PROC_MTXV_SP);
        // Request count from the loop extents, with the count in its slot
        case (c_proc)
            PROC_MXV_SP:  n_req = (c_lim0 + 1) * (c_nzn + 1) * (c_lim2 + 1);
            PROC_MTXV_SP: n_req = (c_lim0 + 1) * (c_lim1 + 1) * (c_nzn + 1);
            default:      n_req = 0;
        endcase
        if (n_req != exp_q.size()) begin
            stop_run($sformatf("Trace case lists %0d requests where %0d are due",
                               exp_q.size(), n_req));
        end
        @(posedge clk);
        cfg_valid     <= 1'b1;
        cfg_proc      <= c_proc;
        cfg_cnt0      <= c_lim0;
        cfg_cnt1      <= c_lim1;
        cfg_cnt2      <= c_lim2;
        smem_addr0    <= c_base;
        nzl_head_addr <= c_haddr;
        nzl_head_peid <= c_hpeid;
        wait_cfg_ready("for acceptance");
        hold = $unsigned($random(seed)) % 6;
        @(posedge clk);
        cfg_valid <= 1'b0;
        if (sparse) begin
            repeat (hold) @(posedge clk);
            pop_allowed = 1'b1;
            empty_nzn <= 1'b0;
            din_nzn   <= c_nzn;
            wait_pop();
            @(posedge clk);
            empty_nzn <= 1'b1;
        end
        wait_cfg_ready("at the end of the run");
        check_flag("rd_avalid", rd_avalid, 1'b0);
        if (exp_q.size() != 0) begin
            stop_run($sformatf("%0d expected requests were never issued", exp_q.size()));
        end
    endtask

    task automatic skip_line(input int fd);
        int c;
        do begin
            c = $fgetc(fd);
        end while (c != 10 && c != -1);
    endtask

    initial begin
        int                fd;
        int                n;
        logic [8*4-1:0]    tag;
        logic [ADDR_W-1:0] r_addr;
        logic [WSEL_W-1:0] r_wsel;
        clk           = 1'b0;
        rstn          = 1'b0;
        cfg_valid     = 1'b0;
        cfg_proc      = PROC_IDLE;
        cfg_cnt0      = '0;
        cfg_cnt1      = '0;
        cfg_cnt2      = '0;
        smem_addr0    = '0;
        nzl_head_addr = '0;
        nzl_head_peid = '0;
        din_nzn       = '0;
        empty_nzn     = 1'b1;
        rd_aready     = 1'b0;
        pop_allowed   = 1'b0;
        fd = $fopen("sim/nzi_req_trace.txt", "r");
        if (fd == 0) begin
            stop_run("Cannot open the trace file sim/nzi_req_trace.txt");
        end
        repeat (16) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        check_flag("cfg_ready", cfg_ready, 1'b1);
        check_flag("rd_avalid", rd_avalid, 1'b0);
        check_flag("pop_nzn", pop_nzn, 1'b0);
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag == "#") begin
                skip_line(fd);
            end else if (tag == "C") begin
                n = $fscanf(fd, "%h %h %h %h %h %h %h %h", c_proc, c_lim0, c_lim1, c_lim2,
                            c_base, c_haddr, c_hpeid, c_nzn);
                if (n != 8) begin
                    stop_run("Malformed configuration line in the trace file");
                end
                exp_q.delete();
            end else if (tag == "R") begin
                n = $fscanf(fd, "%h %h", r_addr, r_wsel);
                if (n != 2) begin
                    stop_run("Malformed request line in the trace file");
                end
                exp_q.push_back({r_addr, r_wsel});
            end else if (tag == "E") begin
                run_case();
            end else begin
                stop_run("Unknown line tag in the trace file");
            end
        end
        $fclose(fd);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* sim/nzi_req_trace.txt */
# C proc lim0 lim1 lim2 smem_addr0 nzl_head_addr nzl_head_peid nzn, all hex
# R rd_addr rd_wsel in issue order, hex; E closes the case
C 1 0 5 1 0100 010 f 2
R 0110 1f
R 0111 10
R 0111 11
R 0110 1f
R 0111 10
R 0111 11
E
C 2 1 1 3 0200 020 e 1
R 0220 1e
R 0220 1e
R 0220 1e
R 0220 1f
R 0221 10
R 0221 10
R 0221 10
R 0221 11
E
C 3 1 1 1 0300 030 0 0
E

/* source/nest_counter.sv */
`timescale 1ns/100ps

module nest_counter import proc_pkg::*; (
    input  logic             clk,
    input  logic             rstn,
    input  logic             load,
    input  logic             step,
    input  logic [CNT_W-1:0] lim0,
    input  logic [CNT_W-1:0] lim1,
    input  logic [CNT_W-1:0] lim2,
    output logic             at_limit1,
    output logic             at_limit01,
    output logic             last
);

    // Inner loop is cnt0, outer loop is cnt2
    logic [CNT_W-1:0] cnt0;
    logic [CNT_W-1:0] cnt1;
    logic [CNT_W-1:0] cnt2;
    logic             at0;
    logic             at1;
    logic             at2;

    // ------------------------------------------------------------------------
    // Limit decode
    // ------------------------------------------------------------------------

    assign at0 = (cnt0 == lim0);
    assign at1 = (cnt1 == lim1);
    assign at2 = (cnt2 == lim2);

    assign at_limit1  = at1;
    assign at_limit01 = at0 && at1;
    assign last       = at0 && at1 && at2;

    // ------------------------------------------------------------------------
    // Counters
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rstn) begin
            cnt0 <= '0;
            cnt1 <= '0;
            cnt2 <= '0;
        end else if (load) begin
            cnt0 <= '0;
            cnt1 <= '0;
            cnt2 <= '0;
        end else if (step) begin
            cnt0 <= at0 ? '0 : cnt0 + 1'b1;
            // Middle moves only on an inner wrap
            if (at0) begin
                cnt1 <= at1 ? '0 : cnt1 + 1'b1;
            end
            if (at0 && at1) begin
                cnt2 <= at2 ? '0 : cnt2 + 1'b1;
            end
        end
    end

endmodule

/* source/nzi_cfg_fsm.sv */
`timescale 1ns/100ps

module nzi_cfg_fsm import proc_pkg::*; (
    input  logic              clk,
    input  logic              rstn,

    // Host configuration
    input  logic              cfg_valid,
    input  logic [PROC_W-1:0] cfg_proc,
    input  logic [CNT_W-1:0]  cfg_cnt0,
    input  logic [CNT_W-1:0]  cfg_cnt1,
    input  logic [CNT_W-1:0]  cfg_cnt2,
    output logic              cfg_ready,

    // Nonzero count queue
    input  logic [CNT_W-1:0]  din_nzn,
    input  logic              empty_nzn,
    output logic              pop_nzn,

    // Datapath control
    input  logic              gen_ready,
    input  logic              last,
    input  logic              out_busy,
    output logic [PROC_W-1:0] proc,
    output logic [CNT_W-1:0]  lim0,
    output logic [CNT_W-1:0]  lim1,
    output logic [CNT_W-1:0]  lim2,
    output logic              load,
    output logic              gen_valid,
    output logic              step
);

    // ------------------------------------------------------------------------
    // State
    // ------------------------------------------------------------------------

    // Idle is encoded as neither flag set
    logic st_init;
    logic st_gen;
    logic idle;
    logic accept;
    logic sparse;
    logic done;

    assign idle   = !st_init && !st_gen;
    assign sparse = (proc == PROC_MXV_SP) || (proc == PROC_MTXV_SP);

    // Ready only once the last request has left the output stage
    assign cfg_ready = idle && !out_busy;
    assign accept    = cfg_valid && cfg_ready;

    // Single pop per run, held off while the queue is empty
    assign pop_nzn = st_init && sparse && !empty_nzn;
    assign load    = pop_nzn;

    assign gen_valid = st_gen;
    assign step      = gen_valid && gen_ready;
    assign done      = step && last;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            st_init <= 1'b0;
            st_gen  <= 1'b0;
        end else if (accept) begin
            st_init <= 1'b1;
        end else if (st_init) begin
            if (!sparse) begin
                // Unknown procedure, release at once
                st_init <= 1'b0;
            end else if (pop_nzn) begin
                st_init <= 1'b0;
                st_gen  <= 1'b1;
            end
        end else if (done) begin
            st_gen <= 1'b0;
        end
    end

    // ------------------------------------------------------------------------
    // Configuration capture
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rstn) begin
            proc <= PROC_IDLE;
        end else if (accept) begin
            proc <= cfg_proc;
        end else if ((st_init && !sparse) || done) begin
            proc <= PROC_IDLE;
        end
    end

    // Popped count overrides one limit, depending on the procedure
    always_ff @(posedge clk) begin
        if (accept) begin
            lim0 <= cfg_cnt0;
            lim1 <= cfg_cnt1;
            lim2 <= cfg_cnt2;
        end else if (pop_nzn) begin
            if (proc == PROC_MXV_SP) begin
                lim1 <= din_nzn;
            end else begin
                lim2 <= din_nzn;
            end
        end
    end

endmodule

/* source/nzi_read_req_gen.sv */
`timescale 1ns/100ps

module nzi_read_req_gen import smem_pkg::*, proc_pkg::*; (
    input  logic                clk,
    input  logic                rstn,

    // Configuration from the host
    input  logic                cfg_valid,
    input  logic [PROC_W-1:0]   cfg_proc,
    input  logic [CNT_W-1:0]    cfg_cnt0,
    input  logic [CNT_W-1:0]    cfg_cnt1,
    input  logic [CNT_W-1:0]    cfg_cnt2,
    input  logic [ADDR_W-1:0]   smem_addr0,
    input  logic [NZL_HA_W-1:0] nzl_head_addr,
    input  logic [PEID_W-1:0]   nzl_head_peid,
    output logic                cfg_ready,

    // Nonzero count queue
    input  logic [CNT_W-1:0]    din_nzn,
    input  logic                empty_nzn,
    output logic                pop_nzn,

    // SMEM read address channel
    output logic [ADDR_W-1:0]   rd_addr,
    output logic [WSEL_W-1:0]   rd_wsel,
    output logic                rd_avalid,
    input  logic                rd_aready
);

    // ------------------------------------------------------------------------
    // Internal wiring
    // ------------------------------------------------------------------------

    logic [PROC_W-1:0]   proc;
    logic [CNT_W-1:0]    lim0;
    logic [CNT_W-1:0]    lim1;
    logic [CNT_W-1:0]    lim2;
    logic                load;
    logic                gen_ready;
    logic                step;
    logic                out_busy;
    logic                at_limit1;
    logic                at_limit01;
    logic                last;
    logic [NZL_HA_W-1:0] nzi_addr;
    logic [PEID_W-1:0]   nzi_peid;

    nzi_cfg_fsm u_cfg_fsm (
        .clk       (clk),
        .rstn      (rstn),
        .cfg_valid (cfg_valid),
        .cfg_proc  (cfg_proc),
        .cfg_cnt0  (cfg_cnt0),
        .cfg_cnt1  (cfg_cnt1),
        .cfg_cnt2  (cfg_cnt2),
        .cfg_ready (cfg_ready),
        .din_nzn   (din_nzn),
        .empty_nzn (empty_nzn),
        .pop_nzn   (pop_nzn),
        .gen_ready (gen_ready),
        .last      (last),
        .out_busy  (out_busy),
        .proc      (proc),
        .lim0      (lim0),
        .lim1      (lim1),
        .lim2      (lim2),
        .load      (load),
        .gen_valid (),
        .step      (step)
    );

    nest_counter u_nest_counter (
        .clk        (clk),
        .rstn       (rstn),
        .load       (load),
        .step       (step),
        .lim0       (lim0),
        .lim1       (lim1),
        .lim2       (lim2),
        .at_limit1  (at_limit1),
        .at_limit01 (at_limit01),
        .last       (last)
    );

    // Head inputs are held by the host for the whole run
    nzl_pointer u_nzl_pointer (
        .clk           (clk),
        .rstn          (rstn),
        .load          (load),
        .step          (step),
        .proc          (proc),
        .at_limit1     (at_limit1),
        .at_limit01    (at_limit01),
        .nzl_head_addr (nzl_head_addr),
        .nzl_head_peid (nzl_head_peid),
        .nzi_addr      (nzi_addr),
        .nzi_peid      (nzi_peid)
    );

    rd_req_stage u_rd_req_stage (
        .clk        (clk),
        .rstn       (rstn),
        .step       (step),
        .smem_addr0 (smem_addr0),
        .nzi_addr   (nzi_addr),
        .nzi_peid   (nzi_peid),
        .gen_ready  (gen_ready),
        .out_busy   (out_busy),
        .rd_addr    (rd_addr),
        .rd_wsel    (rd_wsel),
        .rd_avalid  (rd_avalid),
        .rd_aready  (rd_aready)
    );

endmodule

/* source/nzl_pointer.sv */
`timescale 1ns/100ps

module nzl_pointer import smem_pkg::*, proc_pkg::*; (
    input  logic                clk,
    input  logic                rstn,
    input  logic                load,
    input  logic                step,
    input  logic [PROC_W-1:0]   proc,
    input  logic                at_limit1,
    input  logic                at_limit01,
    input  logic [NZL_HA_W-1:0] nzl_head_addr,
    input  logic [PEID_W-1:0]   nzl_head_peid,
    output logic [NZL_HA_W-1:0] nzi_addr,
    output logic [PEID_W-1:0]   nzi_peid
);

    logic [NZL_HA_W-1:0] head_addr;
    logic [PEID_W-1:0]   head_peid;
    logic [NZL_HA_W-1:0] next_addr;
    logic                peid_wrap;

    // ------------------------------------------------------------------------
    // Pointer advance
    // ------------------------------------------------------------------------

    // PE id wraps into the next list word
    assign peid_wrap = (nzi_peid == PEID_W'(NUM_PE - 1));
    assign next_addr = peid_wrap ? nzi_addr + 1'b1 : nzi_addr;

    // Head held for the MxV_SP rewind
    always_ff @(posedge clk) begin
        if (load) begin
            head_addr <= nzl_head_addr;
            head_peid <= nzl_head_peid;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            nzi_addr <= '0;
            nzi_peid <= '0;
        end else if (load) begin
            nzi_addr <= nzl_head_addr;
            nzi_peid <= nzl_head_peid;
        end else if (step) begin
            if (proc == PROC_MXV_SP) begin
                // Back to the head at the end of each outer round
                if (at_limit01) begin
                    nzi_addr <= head_addr;
                    nzi_peid <= head_peid;
                end else begin
                    nzi_addr <= next_addr;
                    nzi_peid <= nzi_peid + 1'b1;
                end
            end else if ((proc == PROC_MTXV_SP) && at_limit1) begin
                nzi_addr <= next_addr;
                nzi_peid <= nzi_peid + 1'b1;
            end
        end
    end

endmodule

/* source/proc_pkg.sv */
package proc_pkg;

    // ------------------------------------------------------------------------
    // Procedure codes
    // ------------------------------------------------------------------------

    localparam int PROC_W = 3;

    localparam logic [PROC_W-1:0] PROC_IDLE    = 3'd0;
    // Sparse matrix times vector
    localparam logic [PROC_W-1:0] PROC_MXV_SP  = 3'd1;
    // Transposed sparse matrix times vector
    localparam logic [PROC_W-1:0] PROC_MTXV_SP = 3'd2;

    // ------------------------------------------------------------------------
    // Loop geometry
    // ------------------------------------------------------------------------

    // Largest loop extent, limits are inclusive
    localparam int MAX_CNT = 256;

    // Loop limits, counters and the popped nonzero count
    localparam int CNT_W = $clog2(MAX_CNT);

endpackage

/* source/rd_req_stage.sv */
`timescale 1ns/100ps

module rd_req_stage import smem_pkg::*; (
    input  logic                clk,
    input  logic                rstn,
    input  logic                step,
    input  logic [ADDR_W-1:0]   smem_addr0,
    input  logic [NZL_HA_W-1:0] nzi_addr,
    input  logic [PEID_W-1:0]   nzi_peid,
    output logic                gen_ready,
    output logic                out_busy,

    // Read address channel
    output logic [ADDR_W-1:0]   rd_addr,
    output logic [WSEL_W-1:0]   rd_wsel,
    output logic                rd_avalid,
    input  logic                rd_aready
);

    // ------------------------------------------------------------------------
    // Output register
    // ------------------------------------------------------------------------

    // Free, or emptied by the handshake in this cycle
    assign gen_ready = !rd_avalid || rd_aready;
    assign out_busy  = rd_avalid;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rd_avalid <= 1'b0;
        end else if (step) begin
            rd_avalid <= 1'b1;
        end else if (rd_aready) begin
            rd_avalid <= 1'b0;
        end
    end

    // Only written on step, so held under back-pressure
    always_ff @(posedge clk) begin
        if (step) begin
            rd_addr <= smem_addr0 + ADDR_W'(nzi_addr);
            // Single word read of one PE slot
            rd_wsel <= {1'b1, nzi_peid};
        end
    end

endmodule

/* source/smem_pkg.sv */
package smem_pkg;

    // ------------------------------------------------------------------------
    // Shared memory geometry
    // ------------------------------------------------------------------------

    // PEs served by one memory word
    localparam int NUM_PE = 16;
    localparam int PEID_W = $clog2(NUM_PE);

    // Word select is {single word flag, PE id}
    localparam int WSEL_W = PEID_W + 1;

    // Nonzero list region
    localparam int NZL_DEPTH = 4096;
    localparam int NZL_HA_W  = $clog2(NZL_DEPTH);

    // Whole SMEM
    localparam int SMEM_DEPTH = 16384;
    localparam int ADDR_W     = $clog2(SMEM_DEPTH);

endpackage

/* sources.f */
source/smem_pkg.sv
source/proc_pkg.sv
source/nzi_cfg_fsm.sv
source/nest_counter.sv
source/nzl_pointer.sv
source/rd_req_stage.sv
source/nzi_read_req_gen.sv
sim/nzi_read_req_gen_assert.sv
sim/nzi_read_req_gen_tb.sv
